// ==== verilog/req_pkg.sv ====
/*
  Shared request definitions for the host request path.
  One req_t travels on every valid/ready link of the subsystem.
  len counts bytes and is never zero on any link.
  last is kept only on the final chunk of a split request.
*/

`default_nettype none

package req_pkg;

    localparam int VADDR_BITS = 48; // virtual address width in bits.
    localparam int LEN_BITS   = 28; // byte count width, so one request moves under 256 MiB.
    localparam int PID_BITS   = 6;  // process tag width.
    localparam int DEST_BITS  = 4;  // destination stream width.

    // One request as seen on every link, 87 bits wide.
    typedef struct packed {
        logic [VADDR_BITS-1:0] vaddr; // start address of the transfer.
        logic [LEN_BITS-1:0]   len;   // byte count, never zero.
        logic [PID_BITS-1:0]   pid;   // tag that names the issuing process.
        logic [DEST_BITS-1:0]  dest;  // destination stream index.
        logic                  last;  // high on the closing piece of a transfer.
    } req_t;

endpackage

`default_nettype wire

// ==== verilog/req_queue.sv ====
/*
  Request queue for one source with registered head.
  QUEUE_DEPTH must be a power of two and at least 2.
  A push shows up at the head one cycle later.
  Push and pop may happen in the same cycle while space is left.
  A push into a full queue is refused even when a pop happens in that cycle.
*/

`timescale 1ns/1ps
`default_nettype none

module req_queue #(
    parameter int QUEUE_DEPTH = 4
) (
    input  logic          aclk,
    input  logic          aresetn,
    input  req_pkg::req_t s_req,
    input  logic          s_valid,
    output logic          s_ready,
    output req_pkg::req_t m_req,
    output logic          m_valid,
    input  logic          m_ready
);
    import req_pkg::*;

    localparam int PTR_BITS = $clog2(QUEUE_DEPTH);     // pointers wrap on their own.
    localparam int CNT_BITS = $clog2(QUEUE_DEPTH + 1); // count must also hold the full value.

    req_t                mem [QUEUE_DEPTH];
    logic [PTR_BITS-1:0] wr_ptr;
    logic [PTR_BITS-1:0] rd_ptr;
    logic [CNT_BITS-1:0] count;
    logic                push;
    logic                pop;

    assign s_ready = (count != CNT_BITS'(QUEUE_DEPTH)); // space left for one more entry.
    assign m_valid = (count != '0);                     // head holds a real request.
    assign m_req   = mem[rd_ptr];                       // head is read straight from the array.
    assign push    = s_valid & s_ready;
    assign pop     = m_valid & m_ready;

    always_ff @(posedge aclk) begin
        if (push) begin
            mem[wr_ptr] <= s_req; // the new entry goes in at the tail.
        end
    end

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) wr_ptr <= wr_ptr + 1'b1;
            if (pop)  rd_ptr <= rd_ptr + 1'b1;
            case ({push, pop})
                2'b10:   count <= count + 1'b1; // only a push this cycle.
                2'b01:   count <= count - 1'b1; // only a pop this cycle.
                default: count <= count;        // both or neither leave the level alone.
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== verilog/meta_reg.sv ====
/*
  Two-entry register slice for req_t.
  One cycle of latency at full throughput.
  s_ready comes from a flop, so no ready path crosses the slice.
  The spare entry catches the one beat accepted while the output stalls.
*/

`timescale 1ns/1ps
`default_nettype none

module meta_reg (
    input  logic          aclk,
    input  logic          aresetn,
    input  req_pkg::req_t s_meta,
    input  logic          s_valid,
    output logic          s_ready,
    output req_pkg::req_t m_meta,
    output logic          m_valid,
    input  logic          m_ready
);
    import req_pkg::*;

    req_t skid;       // spare entry for the beat taken during a stall.
    logic skid_valid; // spare entry is occupied.

    assign s_ready = ~skid_valid; // inverted flop output, high whenever the spare is free.

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            m_valid    <= 1'b0;
            skid_valid <= 1'b0;
        end else if (skid_valid) begin
            // input is closed, so only the drain of the spare can happen.
            if (m_ready) begin
                m_valid    <= 1'b1;  // spare moves into the main entry.
                skid_valid <= 1'b0;  // which reopens the input next cycle.
            end
        end else if (s_valid) begin
            if (!m_valid || m_ready) begin
                m_valid <= 1'b1;     // main entry is free or leaving, take the beat there.
            end else begin
                skid_valid <= 1'b1;  // main entry is stuck, park the beat in the spare.
            end
        end else if (m_ready) begin
            m_valid <= 1'b0;         // main entry left and nothing replaces it.
        end
    end

    always_ff @(posedge aclk) begin
        if (skid_valid) begin
            if (m_ready) m_meta <= skid;
        end else if (s_valid) begin
            if (!m_valid || m_ready) m_meta <= s_meta;
            else                     skid   <= s_meta;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/req_arb_2_1.sv ====
/*
  Round-robin 2:1 arbiter in front of a meta_reg slice.
  The pointer rr starts at 0, which gives source 1 priority first.
  rr flips on every beat accepted by the slice.
  A lone valid source always wins.
  Output data lags the winning handshake by one cycle.
*/

`timescale 1ns/1ps
`default_nettype none

module req_arb_2_1 (
    input  logic          aclk,
    input  logic          aresetn,
    input  req_pkg::req_t s_req_0,
    input  logic          s_valid_0,
    output logic          s_ready_0,
    input  req_pkg::req_t s_req_1,
    input  logic          s_valid_1,
    output logic          s_ready_1,
    output req_pkg::req_t m_req,
    output logic          m_valid,
    input  logic          m_ready
);
    import req_pkg::*;

    logic rr;            // 0 favours source 1, 1 favours source 0.
    logic sel_1;         // source 1 holds the grant this cycle.
    req_t req_int;       // selected head on its way into the slice.
    logic req_int_valid;
    logic req_int_ready; // registered ready from the slice.

    always_comb begin
        if (s_valid_0 && s_valid_1) begin
            sel_1 = ~rr;       // both waiting, so the pointer decides.
        end else begin
            sel_1 = s_valid_1; // at most one waiting, so it wins alone.
        end
        req_int       = sel_1 ? s_req_1 : s_req_0;
        req_int_valid = s_valid_0 | s_valid_1;
        s_ready_0     = req_int_ready & s_valid_0 & ~sel_1; // ready reaches only the winner.
        s_ready_1     = req_int_ready & sel_1;              // sel_1 already implies s_valid_1.
    end

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            rr <= 1'b0;
        end else if (req_int_valid && req_int_ready) begin
            rr <= ~rr; // hand priority to the other side after each accepted beat.
        end
    end

    meta_reg u_meta_reg (
        .aclk    (aclk),
        .aresetn (aresetn),
        .s_meta  (req_int),
        .s_valid (req_int_valid),
        .s_ready (req_int_ready),
        .m_meta  (m_req),
        .m_valid (m_valid),
        .m_ready (m_ready)
    );

endmodule

`default_nettype wire

// ==== verilog/req_splitter.sv ====
/*
  Request splitter into chunks of at most MAX_LEN bytes.
  MAX_LEN must be a power of two below 2**LEN_BITS.
  A request of L bytes leaves as ceil(L/MAX_LEN) chunks, one per cycle.
  The final chunk carries the remainder, or a full MAX_LEN when there is none.
  Only the final chunk keeps the input's last flag.
  The next request is taken in the cycle the final chunk leaves.
*/

`timescale 1ns/1ps
`default_nettype none

module req_splitter #(
    parameter int MAX_LEN = 4096
) (
    input  logic          aclk,
    input  logic          aresetn,
    input  req_pkg::req_t s_req,
    input  logic          s_valid,
    output logic          s_ready,
    output req_pkg::req_t m_req,
    output logic          m_valid,
    input  logic          m_ready
);
    import req_pkg::*;

    localparam logic [LEN_BITS-1:0]   CHUNK_LEN  = LEN_BITS'(MAX_LEN);   // length of a full chunk.
    localparam logic [VADDR_BITS-1:0] CHUNK_STEP = VADDR_BITS'(MAX_LEN); // address step per chunk.

    req_t cur;        // request in progress, vaddr and len track what is still to go.
    logic final_chunk; // remaining bytes fit in one chunk.
    logic s_fire;
    logic m_fire;

    assign final_chunk = (cur.len <= CHUNK_LEN);
    assign m_fire      = m_valid & m_ready;
    assign s_ready     = ~m_valid | (m_ready & final_chunk); // free now, or free after this beat.
    assign s_fire      = s_valid & s_ready;

    // the outgoing chunk is shaped from the held state without extra delay.
    always_comb begin
        m_req       = cur;
        m_req.len   = final_chunk ? cur.len : CHUNK_LEN; // remainder only on the closing chunk.
        m_req.last  = final_chunk & cur.last;            // earlier chunks never close the transfer.
    end

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            m_valid <= 1'b0;
        end else if (s_fire) begin
            m_valid <= 1'b1;  // a new request starts with its first chunk next cycle.
        end else if (m_fire && final_chunk) begin
            m_valid <= 1'b0;  // the request is done and nothing follows yet.
        end
    end

    always_ff @(posedge aclk) begin
        if (s_fire) begin
            cur <= s_req;     // capture the whole request, chunking starts from here.
        end else if (m_fire && !final_chunk) begin
            cur.vaddr <= cur.vaddr + CHUNK_STEP; // next chunk starts one MAX_LEN further on.
            cur.len   <= cur.len - CHUNK_LEN;    // bytes still owed after this chunk.
        end
    end

endmodule

`default_nettype wire

// ==== verilog/req_top.sv ====
/*
  Host request path with two sources sharing one outbound channel.
  Each source has its own queue in front of a round-robin arbiter.
  The arbiter's slice feeds a splitter that cuts chunks of MAX_LEN bytes.
  With no stall the first chunk leaves three cycles after the input beat.
*/

`timescale 1ns/1ps
`default_nettype none

module req_top #(
    parameter int QUEUE_DEPTH = 4,
    parameter int MAX_LEN     = 4096
) (
    input  logic          aclk,
    input  logic          aresetn,
    input  req_pkg::req_t s_req_0,
    input  logic          s_req_0_valid,
    output logic          s_req_0_ready,
    input  req_pkg::req_t s_req_1,
    input  logic          s_req_1_valid,
    output logic          s_req_1_ready,
    output req_pkg::req_t m_req,
    output logic          m_valid,
    input  logic          m_ready
);
    import req_pkg::*;

    req_t q0_req;  // head of the read queue.
    logic q0_valid;
    logic q0_ready;
    req_t q1_req;  // head of the write queue.
    logic q1_valid;
    logic q1_ready;
    req_t arb_req; // arbitrated request leaving the slice.
    logic arb_valid;
    logic arb_ready;

    req_queue #(.QUEUE_DEPTH(QUEUE_DEPTH)) u_queue_0 (
        .aclk (aclk), .aresetn (aresetn),
        .s_req (s_req_0), .s_valid (s_req_0_valid), .s_ready (s_req_0_ready),
        .m_req (q0_req), .m_valid (q0_valid), .m_ready (q0_ready)
    );

    req_queue #(.QUEUE_DEPTH(QUEUE_DEPTH)) u_queue_1 (
        .aclk (aclk), .aresetn (aresetn),
        .s_req (s_req_1), .s_valid (s_req_1_valid), .s_ready (s_req_1_ready),
        .m_req (q1_req), .m_valid (q1_valid), .m_ready (q1_ready)
    );

    req_arb_2_1 u_arb (
        .aclk (aclk), .aresetn (aresetn),
        .s_req_0 (q0_req), .s_valid_0 (q0_valid), .s_ready_0 (q0_ready),
        .s_req_1 (q1_req), .s_valid_1 (q1_valid), .s_ready_1 (q1_ready),
        .m_req (arb_req), .m_valid (arb_valid), .m_ready (arb_ready)
    );

    req_splitter #(.MAX_LEN(MAX_LEN)) u_splitter (
        .aclk (aclk), .aresetn (aresetn),
        .s_req (arb_req), .s_valid (arb_valid), .s_ready (arb_ready),
        .m_req (m_req), .m_valid (m_valid), .m_ready (m_ready)
    );

endmodule

`default_nettype wire

// ==== test/req_assertions.sv ====
/*
  Handshake checks bound into every req_top instance.
  q0_ready and q1_ready are the arbiter's grants toward the two queues.
  slice_ready is the ready of the arbiter's slice, taken from inside u_arb.
  All checks are off while aresetn is low.
*/

`timescale 1ns/1ps
`default_nettype none

module req_assertions (
    input logic          aclk,
    input logic          aresetn,
    input req_pkg::req_t m_req,
    input logic          m_valid,
    input logic          m_ready,
    input logic          q0_valid,
    input logic          q0_ready,
    input logic          q1_valid,
    input logic          q1_ready,
    input logic          slice_ready
);

    // a stalled chunk must not change under the consumer.
    a_hold_data : assert property (@(posedge aclk) disable iff (!aresetn)
        (m_valid && !m_ready) |=> $stable(m_req))
        else $error("m_req changed while m_valid was high and m_ready low");

    // valid may only fall after its transfer.
    a_hold_valid : assert property (@(posedge aclk) disable iff (!aresetn)
        (m_valid && !m_ready) |=> m_valid)
        else $error("m_valid dropped before its transfer");

    // with a queue waiting and room in the slice, exactly one queue is granted.
    a_one_grant : assert property (@(posedge aclk) disable iff (!aresetn)
        ((q0_valid || q1_valid) && slice_ready)
            |-> ((q0_valid && q0_ready) != (q1_valid && q1_ready)))
        else $error("queue grants into the arbiter were not exactly one");

endmodule

bind req_top req_assertions u_req_assertions (
    .aclk        (aclk),
    .aresetn     (aresetn),
    .m_req       (m_req),
    .m_valid     (m_valid),
    .m_ready     (m_ready),
    .q0_valid    (q0_valid),
    .q0_ready    (q0_ready),
    .q1_valid    (q1_valid),
    .q1_ready    (q1_ready),
    .slice_ready (u_arb.req_int_ready)
);

`default_nettype wire

// ==== test/tb_req_top.sv ====
/*
  Testbench for req_top with QUEUE_DEPTH 4 and MAX_LEN 4096.
  Stimulus comes from one table whose entries are grouped by m_ready pattern.
  pid bit 5 names the source and bits 4..0 the table index, so 32 entries at most.
  The fill phase runs first, while the arbiter pointer still holds its reset value.
  Expected chunks follow the split rule and are matched to a source by pid.
*/

`timescale 1ns/1ps
`default_nettype none

module tb_req_top;
    import req_pkg::*;

    localparam int QUEUE_DEPTH  = 4;
    localparam int MAX_LEN      = 4096;
    localparam int HALF_PERIOD  = 20; // gives the 40 ns clock.
    localparam int RESET_CYCLES = 8;

    localparam logic [1:0] STALL_NONE = 2'd0; // m_ready stays high.
    localparam logic [1:0] STALL_FILL = 2'd1; // m_ready low until both sources are queued.
    localparam logic [1:0] STALL_RAND = 2'd2; // m_ready drawn at random every cycle.

    typedef struct packed {
        logic                  src;   // 0 is the read source, 1 the write source.
        logic [VADDR_BITS-1:0] vaddr;
        logic [LEN_BITS-1:0]   len;
        logic [DEST_BITS-1:0]  dest;
        logic                  last;
        logic [1:0]            stall; // m_ready pattern of the phase this entry runs in.
    } stim_t;

    typedef struct packed {
        req_t req;     // chunk as it must leave the DUT.
        logic closing; // final chunk of its request.
    } exp_t;

    logic aclk;
    logic aresetn;
    req_t s_req_0;
    logic s_req_0_valid;
    logic s_req_0_ready;
    req_t s_req_1;
    logic s_req_1_valid;
    logic s_req_1_ready;
    req_t m_req;
    logic m_valid;
    logic m_ready;

    stim_t               stim [$];  // the stimulus table.
    exp_t                exp_0 [$]; // chunks still owed to source 0, in order.
    exp_t                exp_1 [$];
    logic                starts [$]; // source of each request as its first chunk leaves.
    logic                open_request; // a request has chunks still to come.
    logic [PID_BITS-1:0] open_pid;
    int                  value_errors;
    int                  other_errors;
    int                  cycle_limit;

    req_top #(
        .QUEUE_DEPTH (QUEUE_DEPTH),
        .MAX_LEN     (MAX_LEN)
    ) u_req_top (
        .aclk (aclk), .aresetn (aresetn),
        .s_req_0 (s_req_0), .s_req_0_valid (s_req_0_valid), .s_req_0_ready (s_req_0_ready),
        .s_req_1 (s_req_1), .s_req_1_valid (s_req_1_valid), .s_req_1_ready (s_req_1_ready),
        .m_req (m_req), .m_valid (m_valid), .m_ready (m_ready)
    );

    initial begin
        aclk = 1'b0;
        forever #HALF_PERIOD aclk = ~aclk;
    end

    task automatic add_stim(input logic src, input logic [VADDR_BITS-1:0] vaddr,
                            input int len, input int dest, input logic last,
                            input logic [1:0] stall);
        stim_t e;
        e.src   = src;
        e.vaddr = vaddr;
        e.len   = LEN_BITS'(len);
        e.dest  = DEST_BITS'(dest);
        e.last  = last;
        e.stall = stall;
        stim.push_back(e);
    endtask

    task automatic build_table();
        // fill phase, equal counts per source so that grants alternate to the end.
        add_stim(1'b0, 48'h0000_1000_0000,    64, 1, 1'b1, STALL_FILL);
        add_stim(1'b1, 48'h0000_2000_0000,  4096, 2, 1'b1, STALL_FILL);
        add_stim(1'b0, 48'h0000_1000_0040,  5000, 1, 1'b0, STALL_FILL);
        add_stim(1'b1, 48'h0000_2000_1000,   100, 2, 1'b1, STALL_FILL);
        add_stim(1'b0, 48'h0000_1000_2000,  8192, 3, 1'b1, STALL_FILL);
        add_stim(1'b1, 48'h0000_2000_3000,     1, 4, 1'b0, STALL_FILL);
        // lengths around MAX_LEN with m_ready high.
        add_stim(1'b0, 48'h00ab_cdef_0123,     1, 5, 1'b1, STALL_NONE);
        add_stim(1'b0, 48'h00ab_cdef_1000,  4095, 5, 1'b1, STALL_NONE);
        add_stim(1'b0, 48'h00ab_cdef_2000,  4096, 6, 1'b1, STALL_NONE);
        add_stim(1'b0, 48'h00ab_cdef_3001,  4097, 6, 1'b1, STALL_NONE);
        add_stim(1'b0, 48'h00ab_cdf0_0000, 12293, 7, 1'b1, STALL_NONE);
        add_stim(1'b1, 48'hfff0_0000_0800,  8192, 8, 1'b0, STALL_NONE);
        add_stim(1'b1, 48'h0000_3000_0000, 20479, 9, 1'b1, STALL_NONE);
        // both sources under random back-pressure.
        add_stim(1'b0, 48'h0000_4000_0000,   300, 10, 1'b1, STALL_RAND);
        add_stim(1'b1, 48'h0000_5000_0000,  9000, 11, 1'b1, STALL_RAND);
        add_stim(1'b0, 48'h0000_4000_1000,  4096, 10, 1'b0, STALL_RAND);
        add_stim(1'b1, 48'h0000_5000_4000,    77, 11, 1'b1, STALL_RAND);
        add_stim(1'b0, 48'h0000_4000_2000, 13000, 12, 1'b1, STALL_RAND);
        add_stim(1'b1, 48'h0000_5000_5000,  4097, 13, 1'b1, STALL_RAND);
        add_stim(1'b0, 48'h0000_4000_6000,    12, 14, 1'b1, STALL_RAND);
        add_stim(1'b1, 48'h0000_5000_7000, 16384, 15, 1'b0, STALL_RAND);
        add_stim(1'b0, 48'h0000_4000_7000,  6000,  0, 1'b1, STALL_RAND);
        add_stim(1'b1, 48'h0000_5000_c000,  4000,  3, 1'b1, STALL_RAND);
    endtask

    function automatic int chunk_count(input logic [LEN_BITS-1:0] len);
        return (int'(len) + MAX_LEN - 1) / MAX_LEN; // ceil(len / MAX_LEN).
    endfunction

    function automatic req_t make_req(input int idx);
        req_t r;
        r.vaddr = stim[idx].vaddr;
        r.len   = stim[idx].len;
        r.pid   = {stim[idx].src, (PID_BITS-1)'(idx)}; // source on top, table index below.
        r.dest  = stim[idx].dest;
        r.last  = stim[idx].last;
        return r;
    endfunction

    // Queue the chunks that one table entry must turn into.
    task automatic add_expected(input int idx);
        req_t head;
        exp_t e;
        int   n;
        head = make_req(idx);
        n    = chunk_count(head.len);
        for (int i = 0; i < n; i++) begin
            e.req       = head;
            e.req.vaddr = head.vaddr + VADDR_BITS'(longint'(i) * MAX_LEN);
            e.req.len   = (i == n - 1) ? head.len - LEN_BITS'((n - 1) * MAX_LEN)
                                       : LEN_BITS'(MAX_LEN); // remainder, or a full chunk.
            e.req.last  = (i == n - 1) ? head.last : 1'b0;
            e.closing   = (i == n - 1);
            if (stim[idx].src) exp_1.push_back(e);
            else               exp_0.push_back(e);
        end
    endtask

    task automatic check_req(input string name, input req_t expected, input req_t observed);
        if (observed !== expected) begin
            value_errors++;
            $display("FAILED at %0t: %s expected vaddr %h len %0d pid %h dest %h last %b",
                     $time, name, expected.vaddr, expected.len, expected.pid,
                     expected.dest, expected.last);
            $display("FAILED at %0t: %s observed vaddr %h len %0d pid %h dest %h last %b",
                     $time, name, observed.vaddr, observed.len, observed.pid,
                     observed.dest, observed.last);
        end
    endtask

    task automatic check_bit(input string name, input logic expected, input logic observed);
        if (observed !== expected) begin
            value_errors++;
            $display("FAILED at %0t: %s expected %b observed %b",
                     $time, name, expected, observed);
        end
    endtask

    // Values read here are those the DUT saw at this edge.
    task automatic watch_output();
        req_t got;
        exp_t want;
        logic src;
        if (m_valid && m_ready) begin
            got = m_req;
            src = got.pid[PID_BITS-1];
            if (open_request && got.pid != open_pid) begin
                other_errors++;
                $display("chunk of pid %h cut into open request %h at %0t",
                         got.pid, open_pid, $time);
            end
            if ((src && exp_1.size() == 0) || (!src && exp_0.size() == 0)) begin
                other_errors++;
                $display("chunk with pid %h arrived but none was expected at %0t",
                         got.pid, $time);
            end else begin
                if (src) want = exp_1.pop_front();
                else     want = exp_0.pop_front();
                if (!open_request) starts.push_back(src); // first chunk of a request.
                check_req("m_req", want.req, got);
                open_request = !want.closing;
                open_pid     = got.pid;
            end
        end
    endtask

    task automatic step_cycle();
        @(posedge aclk);
        watch_output();
    endtask

    task automatic drive_ready(input logic [1:0] code);
        case (code)
            STALL_FILL: m_ready <= 1'b0;
            STALL_RAND: m_ready <= ($urandom % 3) != 0; // ready about two cycles in three.
            default:    m_ready <= 1'b1;
        endcase
    endtask

    function automatic logic skip_beat(input logic [1:0] code);
        return (code == STALL_RAND) && (($urandom % 4) == 0); // idle source cycles.
    endfunction

    // Apply every table entry of one phase and wait until all its chunks are out.
    task automatic run_phase(input logic [1:0] code);
        int   list_0 [$];
        int   list_1 [$];
        logic busy;
        foreach (stim[k]) begin
            if (stim[k].stall == code) begin
                add_expected(k);
                if (stim[k].src) list_1.push_back(k);
                else             list_0.push_back(k);
            end
        end
        starts.delete();
        busy = 1'b1;
        while (busy) begin
            step_cycle();
            if (!s_req_0_valid || s_req_0_ready) begin // slot free or its beat just went.
                if (list_0.size() != 0 && !skip_beat(code)) begin
                    s_req_0       <= make_req(list_0.pop_front());
                    s_req_0_valid <= 1'b1;
                end else begin
                    s_req_0_valid <= 1'b0;
                end
            end
            if (!s_req_1_valid || s_req_1_ready) begin
                if (list_1.size() != 0 && !skip_beat(code)) begin
                    s_req_1       <= make_req(list_1.pop_front());
                    s_req_1_valid <= 1'b1;
                end else begin
                    s_req_1_valid <= 1'b0;
                end
            end
            drive_ready(code);
            busy = list_0.size() != 0 || list_1.size() != 0 || s_req_0_valid || s_req_1_valid;
        end
        while (exp_0.size() != 0 || exp_1.size() != 0) begin
            drive_ready((code == STALL_FILL) ? STALL_NONE : code); // the fill stall ends here.
            step_cycle();
        end
        step_cycle();
        check_bit("m_valid", 1'b0, m_valid);
        check_bit("s_req_0_ready", 1'b1, s_req_0_ready);
        check_bit("s_req_1_ready", 1'b1, s_req_1_ready);
    endtask

    initial begin : main
        int seed_value;
        int total_chunks;
        aresetn       = 1'b0;
        s_req_0       = '0;
        s_req_0_valid = 1'b0;
        s_req_1       = '0;
        s_req_1_valid = 1'b0;
        m_ready       = 1'b0;
        value_errors  = 0;
        other_errors  = 0;
        open_request  = 1'b0;
        open_pid      = '0;
        seed_value    = $urandom(32'hf1dd543f);
        build_table();
        total_chunks = 0;
        foreach (stim[k]) total_chunks += chunk_count(stim[k].len);
        cycle_limit = 40 * total_chunks + 200;

        repeat (RESET_CYCLES) @(posedge aclk);
        aresetn <= 1'b1;
        step_cycle();
        check_bit("m_valid", 1'b0, m_valid);
        check_bit("s_req_0_ready", 1'b1, s_req_0_ready);
        check_bit("s_req_1_ready", 1'b1, s_req_1_ready);

        run_phase(STALL_FILL);
        for (int i = 0; i < starts.size(); i++) begin
            check_bit("first chunk source", (i % 2 == 0), starts[i]); // source 1 leads.
        end
        run_phase(STALL_NONE);
        run_phase(STALL_RAND);

        $display("errors: %0d total, %0d value mismatches, %0d other failures",
                 value_errors + other_errors, value_errors, other_errors);
        if (value_errors + other_errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

    initial begin : watchdog
        wait (cycle_limit != 0);
        for (int c = 0; c < cycle_limit; c++) @(posedge aclk);
        $display("timeout: run did not finish within %0d cycles", cycle_limit);
        $display("TEST FAIL");
        $finish;
    end

endmodule

`default_nettype wire

// ==== sim.f ====
verilog/req_pkg.sv
verilog/req_queue.sv
verilog/meta_reg.sv
verilog/req_arb_2_1.sv
verilog/req_splitter.sv
verilog/req_top.sv
test/req_assertions.sv
test/tb_req_top.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Builds tb_req_top with Verilator and runs it.
# The run counts as failed when a step fails or the log holds the fail message.

set -u
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_req_top -f sim.f -o tb_req_top_sim
if [ $? -ne 0 ]; then
    echo "run.sh: verilator build failed"
    exit 1
fi

./obj_dir/tb_req_top_sim > "$LOG" 2>&1
run_status=$?
cat "$LOG"
if [ $run_status -ne 0 ]; then
    echo "run.sh: simulation exited with status $run_status"
    exit 1
fi

if grep -q "TEST FAIL" "$LOG"; then
    echo "run.sh: failure reported in $LOG"
    exit 1
fi

echo "run.sh: no failure reported"
exit 0
